// File: hdl/ahbMatrix_settings.svh
`ifndef AHB_MATRIX_SETTINGS_SVH
`define AHB_MATRIX_SETTINGS_SVH

`define AHB_DEVICE_COUNT      3

// ------------------------------------------------------------
// memory sizes, word address bits
`define RESET_RAM_ADDR_WIDTH  8
`define RAM_ADDR_WIDTH        10
`define RAM_WAIT_STATES       2

// address matches, compared against the listed HADDR bits
`define RESET_RAM_MATCH       7'h7f  // HADDR[28:22], 0x1fc00000 physical
`define RAM_MATCH             3'h0   // HADDR[28:26]
`define GPIO_MATCH            7'h7e  // HADDR[28:22], 0x1f800000 physical

// ------------------------------------------------------------
// board io widths
`define N_SWITCHES            18
`define N_BUTTONS             5
`define N_RED_LEDS            18
`define N_GREEN_LEDS          9
`define HEX_WIDTH             32

// gpio register offsets inside the gpio window
`define GPIO_RED_OFFSET       8'h00
`define GPIO_GREEN_OFFSET     8'h04
`define GPIO_HEX_OFFSET       8'h08
`define GPIO_SWITCH_OFFSET    8'h80
`define GPIO_BUTTON_OFFSET    8'h84

`endif

// File: hdl/ahbMatrixPkg.sv
`include "ahbMatrix_settings.svh"

package ahbMatrixPkg;

    typedef logic [31:0] haddrT;
    typedef logic [31:0] hdataT;
    typedef logic [2:0]  hsizeT;
    typedef logic [1:0]  htransT;  // bit 1 set for NONSEQ and SEQ

    // one bit per slave, one-hot in normal use
    typedef logic [`AHB_DEVICE_COUNT-1:0] hselT;

    // ------------------------------------------------------------
    // address-phase request, shared by all slaves
    typedef struct packed {
        haddrT  haddr;
        hsizeT  hsize;
        htransT htrans;
        logic   hwrite;
    } ahbReqT;

    // data-phase response of a single slave
    typedef struct packed {
        hdataT hrdata;
        logic  hready;
        logic  hresp;
    } ahbRspT;

    // slave slots in the select vector
    localparam int slotResetRam = 0;
    localparam int slotRam      = 1;
    localparam int slotGpio     = 2;

endpackage

// File: hdl/ahbDecoder.sv
`include "ahbMatrix_settings.svh"

module ahbDecoder (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  ahbMatrixPkg::haddrT haddr,
    input  logic                ready,     // matrix-wide HREADY, marks phase change
    output ahbMatrixPkg::hselT  hselAddr,  // address-phase select
    output ahbMatrixPkg::hselT  hselData   // data-phase select
);

    import ahbMatrixPkg::*;

    hselT hselQ;  // raw decode, not yet gated

    // ------------------------------------------------------------
    // address decode on the physical address bits
    always_comb begin
        hselQ = '0;
        hselQ[slotResetRam] = (haddr[28:22] == `RESET_RAM_MATCH);  // 4 MB window
        hselQ[slotRam]      = (haddr[28:26] == `RAM_MATCH);        // 64 MB window
        hselQ[slotGpio]     = (haddr[28:22] == `GPIO_MATCH);       // 4 MB window
    end

    // no new address phase while a data phase is stretched
    assign hselAddr = ready ? hselQ : '0;

    // ------------------------------------------------------------
    // data-phase select, advances only when the bus moves on
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            hselData <= '0;
        end else if (ready) begin
            hselData <= hselAddr;
        end
    end

endmodule

// File: hdl/ahbResponseMux.sv
module ahbResponseMux (
    input  ahbMatrixPkg::hselT   hselData,
    input  ahbMatrixPkg::ahbRspT rspResetRam,
    input  ahbMatrixPkg::ahbRspT rspRam,
    input  ahbMatrixPkg::ahbRspT rspGpio,
    output ahbMatrixPkg::hdataT  HRDATA,
    output logic                 HREADY,
    output logic                 HRESP
);

    import ahbMatrixPkg::*;

    ahbRspT selRsp;

    // lowest select bit wins, unmapped falls back to main ram
    always_comb begin
        if (hselData[slotResetRam]) begin
            selRsp = rspResetRam;
        end else if (hselData[slotRam]) begin
            selRsp = rspRam;
        end else if (hselData[slotGpio]) begin
            selRsp = rspGpio;
        end else begin
            selRsp = rspRam;  // default route
        end
    end

    assign HRDATA = selRsp.hrdata;
    assign HRESP  = selRsp.hresp;

    // idle slaves keep hready high, so the AND follows the active one
    assign HREADY = rspResetRam.hready & rspRam.hready & rspGpio.hready;

endmodule

// File: hdl/ahbRamSlave.sv
module ahbRamSlave #(
    parameter int addrWidth  = 8,
    parameter int waitStates = 0
) (
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  ahbMatrixPkg::ahbReqT req,
    input  logic                 sel,
    input  logic                 ready,
    input  ahbMatrixPkg::hdataT  hwdata,
    output ahbMatrixPkg::ahbRspT rsp
);

    import ahbMatrixPkg::*;

    localparam int cntWidth = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

    hdataT                mem [0:2**addrWidth-1];
    logic [addrWidth-1:0] wordAddr;   // data-phase word address
    logic [3:0]           byteMask;   // data-phase byte lanes
    logic [3:0]           maskNext;
    logic                 writeFlag;  // data phase is a write
    logic [cntWidth-1:0]  waitCnt;    // wait cycles left
    logic                 accept;

    assign accept = sel & req.htrans[1] & ready;

    // ------------------------------------------------------------
    // byte lanes from size and low address bits, little-endian
    always_comb begin
        case (req.hsize)
            3'd0:    maskNext = 4'b0001 << req.haddr[1:0];
            3'd1:    maskNext = req.haddr[1] ? 4'b1100 : 4'b0011;
            default: maskNext = 4'b1111;  // word
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            writeFlag <= 1'b0;
            waitCnt   <= '0;
        end else begin
            if (ready) writeFlag <= accept & req.hwrite;
            if (accept) begin
                waitCnt <= cntWidth'(waitStates);
            end else if (waitCnt != '0) begin
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            wordAddr <= req.haddr[addrWidth+1:2];
            byteMask <= maskNext;
        end
    end

    // ------------------------------------------------------------
    // write lands at the end of the completing data phase
    always_ff @(posedge HCLK) begin
        if (writeFlag && ready) begin
            for (int i = 0; i < 4; i++) begin
                if (byteMask[i]) mem[wordAddr][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
    end

    // asynchronous read of the registered word
    assign rsp = '{hrdata: mem[wordAddr], hready: (waitCnt == '0), hresp: 1'b0};

endmodule

// File: hdl/ahbGpioSlave.sv
`include "ahbMatrix_settings.svh"

module ahbGpioSlave (
    input  logic                         HCLK,
    input  logic                         HRESETn,
    input  ahbMatrixPkg::ahbReqT         req,
    input  logic                         sel,
    input  logic                         ready,
    input  ahbMatrixPkg::hdataT          hwdata,
    output ahbMatrixPkg::ahbRspT         rsp,
    input  logic [`N_SWITCHES-1:0]       switches,
    input  logic [`N_BUTTONS-1:0]        buttons,
    output logic [`N_RED_LEDS-1:0]       redLeds,
    output logic [`N_GREEN_LEDS-1:0]     greenLeds,
    output logic [`HEX_WIDTH-1:0]        hexDisplay
);

    import ahbMatrixPkg::*;

    logic [7:0]             gpioOffset;  // data-phase register offset
    logic                   writeFlag;
    logic [`N_SWITCHES-1:0] switchSample;
    logic [`N_BUTTONS-1:0]  buttonSample;
    hdataT                  readData;

    // ------------------------------------------------------------
    // address phase capture
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            writeFlag <= 1'b0;
        end else if (ready) begin
            writeFlag <= sel & req.htrans[1] & req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (sel && req.htrans[1] && ready) gpioOffset <= req.haddr[7:0];
        switchSample <= switches;  // board inputs, one sample per cycle
        buttonSample <= buttons;
    end

    // output registers, written in the data phase
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            redLeds    <= '0;
            greenLeds  <= '0;
            hexDisplay <= '0;
        end else if (writeFlag && ready) begin
            case (gpioOffset)
                `GPIO_RED_OFFSET:   redLeds    <= hwdata[`N_RED_LEDS-1:0];
                `GPIO_GREEN_OFFSET: greenLeds  <= hwdata[`N_GREEN_LEDS-1:0];
                `GPIO_HEX_OFFSET:   hexDisplay <= hwdata[`HEX_WIDTH-1:0];
                default: ;  // read-only or unused offset
            endcase
        end
    end

    // ------------------------------------------------------------
    always_comb begin
        case (gpioOffset)
            `GPIO_RED_OFFSET:    readData = hdataT'(redLeds);
            `GPIO_GREEN_OFFSET:  readData = hdataT'(greenLeds);
            `GPIO_HEX_OFFSET:    readData = hdataT'(hexDisplay);
            `GPIO_SWITCH_OFFSET: readData = hdataT'(switchSample);
            `GPIO_BUTTON_OFFSET: readData = hdataT'(buttonSample);
            default:             readData = '0;
        endcase
    end

    assign rsp = '{hrdata: readData, hready: 1'b1, hresp: 1'b0};  // never stalls

endmodule

// File: hdl/ahbMatrix.sv
`include "ahbMatrix_settings.svh"

module ahbMatrix (
    input  logic                       HCLK,
    input  logic                       HRESETn,
    input  ahbMatrixPkg::haddrT        HADDR,
    input  ahbMatrixPkg::hsizeT        HSIZE,
    input  ahbMatrixPkg::htransT       HTRANS,
    input  logic                       HWRITE,
    input  ahbMatrixPkg::hdataT        HWDATA,
    output ahbMatrixPkg::hdataT        HRDATA,
    output logic                       HREADY,
    output logic                       HRESP,
    input  logic [`N_SWITCHES-1:0]     switches,
    input  logic [`N_BUTTONS-1:0]      buttons,
    output logic [`N_RED_LEDS-1:0]     redLeds,
    output logic [`N_GREEN_LEDS-1:0]   greenLeds,
    output logic [`HEX_WIDTH-1:0]      hexDisplay
);

    import ahbMatrixPkg::*;

    ahbReqT req;
    hselT   hselAddr;  // address phase, gated by HREADY
    hselT   hselData;  // data phase
    ahbRspT rspResetRam;
    ahbRspT rspRam;
    ahbRspT rspGpio;

    assign req = '{haddr: HADDR, hsize: HSIZE, htrans: HTRANS, hwrite: HWRITE};

    // ------------------------------------------------------------
    ahbDecoder decoder (
        .HCLK(HCLK), .HRESETn(HRESETn), .haddr(HADDR), .ready(HREADY),
        .hselAddr(hselAddr), .hselData(hselData)
    );

    // reset vector ram, single-cycle data phase
    ahbRamSlave #(.addrWidth(`RESET_RAM_ADDR_WIDTH), .waitStates(0)) resetRam (
        .HCLK(HCLK), .HRESETn(HRESETn), .req(req), .sel(hselAddr[slotResetRam]),
        .ready(HREADY), .hwdata(HWDATA), .rsp(rspResetRam)
    );

    ahbRamSlave #(.addrWidth(`RAM_ADDR_WIDTH), .waitStates(`RAM_WAIT_STATES)) ram (
        .HCLK(HCLK), .HRESETn(HRESETn), .req(req), .sel(hselAddr[slotRam]),
        .ready(HREADY), .hwdata(HWDATA), .rsp(rspRam)
    );

    ahbGpioSlave gpio (
        .HCLK(HCLK), .HRESETn(HRESETn), .req(req), .sel(hselAddr[slotGpio]),
        .ready(HREADY), .hwdata(HWDATA), .rsp(rspGpio),
        .switches(switches), .buttons(buttons),
        .redLeds(redLeds), .greenLeds(greenLeds), .hexDisplay(hexDisplay)
    );

    // response steering back to the master
    ahbResponseMux responseMux (
        .hselData(hselData), .rspResetRam(rspResetRam), .rspRam(rspRam),
        .rspGpio(rspGpio), .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP)
    );

endmodule

// File: verif/ahbMatrix_sva.sv
module ahbMatrixSva (
    input logic               HCLK,
    input logic               HRESETn,
    input logic               ready,
    input ahbMatrixPkg::hselT hselAddr,
    input ahbMatrixPkg::hselT hselData
);
    timeunit 1ns;
    timeprecision 100ps;

    // data-phase select names at most one slave
    selOneHot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(hselData))
        else $error("hselData not one-hot: %b", hselData);

    // a stretched data phase keeps its slave
    selHeld: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !ready |=> $stable(hselData))
        else $error("hselData changed while ready was low");

    addrGated: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !ready |-> hselAddr == '0)  // no new address phase during a stretch
        else $error("hselAddr %b while ready was low", hselAddr);

endmodule

bind ahbDecoder ahbMatrixSva decoderSva (
    .HCLK(HCLK), .HRESETn(HRESETn), .ready(ready), .hselAddr(hselAddr), .hselData(hselData)
);

// File: verif/ahbMatrixTb.sv
`include "ahbMatrix_settings.svh"

module ahbMatrixTb;
    timeunit 1ns;
    timeprecision 100ps;

    import ahbMatrixPkg::*;

    typedef struct packed {
        logic                   isWrite;
        haddrT                  addr;
        hsizeT                  size;
        hdataT                  data;  // write data, or expected read data
        logic [`N_SWITCHES-1:0] switches;
        logic [`N_BUTTONS-1:0]  buttons;
    } traceLineT;

    logic   HCLK, HRESETn, HWRITE, HREADY, HRESP;
    haddrT  HADDR;
    hsizeT  HSIZE;
    htransT HTRANS;
    hdataT  HWDATA, HRDATA;
    logic [`N_SWITCHES-1:0]   switches;
    logic [`N_BUTTONS-1:0]    buttons;
    logic [`N_RED_LEDS-1:0]   redLeds, expRed;  // exp* follow the gpio writes
    logic [`N_GREEN_LEDS-1:0] greenLeds, expGreen;
    logic [`HEX_WIDTH-1:0]    hexDisplay, expHex;

    traceLineT trace[$];
    hdataT     refMem[haddrT];  // word model of both rams, keyed by word address
    int        errors = 0;
    int        failedTests = 0;
    int        cycleCount = 0;
    int        cycleLimit = 100;

    ahbMatrix uut (.*);

    initial HCLK = 1'b0;
    always #4 HCLK = ~HCLK;

    always @(posedge HCLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: trace not done after %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------
    task automatic logError(string msg);
        $display("%s", msg);
        errors++;
    endtask

    function automatic int slotOf(haddrT addr);
        if (addr[28:22] == `RESET_RAM_MATCH) return slotResetRam;
        if (addr[28:26] == `RAM_MATCH) return slotRam;
        if (addr[28:22] == `GPIO_MATCH) return slotGpio;
        return -1;  // unmapped
    endfunction

    // little-endian, byte lane n carries address offset n
    function automatic hdataT mergeLanes(hdataT word, traceLineT t);
        for (int lane = 0; lane < 4; lane++) begin
            if (t.size >= 3'd2 || (t.size == 3'd1 && lane[1] == t.addr[1])
                    || lane[1:0] == t.addr[1:0]) begin
                word[8*lane +: 8] = t.data[8*lane +: 8];
            end
        end
        return word;
    endfunction

    task automatic loadTrace();
        int                     fd;
        int                     fields;
        string                  line;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [2:0]             size;
        logic [`N_SWITCHES-1:0] sw;
        logic [`N_BUTTONS-1:0]  btn;
        fd = $fopen("verif/ahbMatrix_trace.txt", "r");
        if (fd == 0) begin
            logError("trace file verif/ahbMatrix_trace.txt could not be opened");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            fields = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
                             addr, size, data, sw, btn);
            if (fields == 5) begin
                trace.push_back(traceLineT'{line.substr(0, 0) == "W", addr, size, data, sw, btn});
            end else begin
                logError($sformatf("malformed trace line: %s", line));
            end
        end
        $fclose(fd);
    endtask

    task automatic driveAddress(traceLineT t);
        HADDR    = t.addr;
        HSIZE    = t.size;
        HTRANS   = 2'b10;  // NONSEQ
        HWRITE   = t.isWrite;
        switches = t.switches;
        buttons  = t.buttons;
    endtask

    task automatic checkGpioOutputs();
        assert ({redLeds, greenLeds, hexDisplay} === {expRed, expGreen, expHex})
        else logError($sformatf("[ERROR] redLeds %h greenLeds %h hexDisplay %h, expected %h %h %h",
                                redLeds, greenLeds, hexDisplay, expRed, expGreen, expHex));
    endtask

    // data phase of line idx, overlapped with the next line's address phase
    task automatic runLine(int idx);
        traceLineT cur;
        haddrT     key;
        int        slot;
        int        expWait;
        int        lowCycles;
        int        errorsBefore;
        cur          = trace[idx];
        key          = {cur.addr[31:2], 2'b00};
        slot         = slotOf(cur.addr);
        expWait      = (slot == slotRam) ? `RAM_WAIT_STATES : 0;
        errorsBefore = errors;
        lowCycles    = 0;
        HWDATA = cur.isWrite ? cur.data : '0;
        if (idx + 1 < trace.size()) begin
            driveAddress(trace[idx + 1]);
        end else begin
            HTRANS = 2'b00;  // idle after the last line
        end
        @(negedge HCLK);
        while (HREADY !== 1'b1) begin
            lowCycles++;
            @(negedge HCLK);
        end
        assert (lowCycles == expWait)
        else logError($sformatf("[ERROR] HREADY low cycles: got %0h, expected %0h",
                                lowCycles, expWait));
        assert (HRESP === 1'b0)
        else logError($sformatf("[ERROR] HRESP: got %h, expected 0", HRESP));
        if (!cur.isWrite) begin
            assert (HRDATA === cur.data)
            else logError($sformatf("[ERROR] HRDATA: got %h, expected %h", HRDATA, cur.data));
            if (refMem.exists(key) && (slot == slotRam || slot == slotResetRam)) begin
                assert (HRDATA === refMem[key])
                else logError($sformatf("[ERROR] HRDATA: got %h, model %h", HRDATA, refMem[key]));
            end
        end
        @(posedge HCLK);
        #1;
        if (cur.isWrite && (slot == slotRam || slot == slotResetRam)) begin
            refMem[key] = mergeLanes(refMem.exists(key) ? refMem[key] : '0, cur);
        end else if (cur.isWrite && slot == slotGpio) begin
            case (cur.addr[7:0])
                `GPIO_RED_OFFSET:   expRed   = cur.data[`N_RED_LEDS-1:0];
                `GPIO_GREEN_OFFSET: expGreen = cur.data[`N_GREEN_LEDS-1:0];
                `GPIO_HEX_OFFSET:   expHex   = cur.data;
                default: ;
            endcase
        end
        checkGpioOutputs();
        if (errors != errorsBefore) failedTests++;
        $display("test %0d: %s %h size %0d %s", idx + 1, cur.isWrite ? "W" : "R",
                 cur.addr, cur.size, (errors == errorsBefore) ? "ok" : "failed");
    endtask

    // ------------------------------------------------------------
    initial begin
        int errorsBefore;
        HRESETn  = 1'b0;
        HADDR    = '0;
        HSIZE    = '0;
        HTRANS   = '0;
        HWRITE   = 1'b0;
        HWDATA   = '0;
        switches = '0;
        buttons  = '0;
        expRed   = '0;
        expGreen = '0;
        expHex   = '0;
        loadTrace();
        cycleLimit = 20 * trace.size() + 100;
        repeat (8) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;

        errorsBefore = errors;  // reset state, before any transfer
        assert (HRESP === 1'b0)
        else logError($sformatf("[ERROR] HRESP after reset: got %h, expected 0", HRESP));
        checkGpioOutputs();
        if (errors != errorsBefore) failedTests++;
        $display("test 0: reset state %s", (errors == errorsBefore) ? "ok" : "failed");

        if (trace.size() > 0) begin
            driveAddress(trace[0]);  // first address phase has no data phase beside it
            @(negedge HCLK);
            while (HREADY !== 1'b1) begin
                @(negedge HCLK);
            end
            @(posedge HCLK);
            #1;
        end
        for (int i = 0; i < trace.size(); i++) begin
            runLine(i);
        end

        $display("%0d tests, %0d failed, %0d errors", trace.size() + 1, failedTests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/ahbMatrix_trace.txt
# op addr size data switches buttons, all hex; W drives data on HWDATA, R expects it on HRDATA
# size 0 byte, 1 halfword, 2 word; byte and halfword data sit in their own lanes
W 00000010 2 11223344 00000 00
R 00000010 2 11223344 00000 00
W 00000011 0 0000aa00 00000 00
R 00000010 2 1122aa44 00000 00
W 00000012 1 beef0000 00000 00
R 00000010 2 beefaa44 00000 00
W 00000020 2 cafef00d 00000 00
W 00000020 1 00001234 00000 00
W 00000023 0 77000000 00000 00
R 00000020 2 77fe1234 00000 00
W 1fc00010 2 deadbeef 00000 00
R 1fc00010 2 deadbeef 00000 00
R 00000010 2 beefaa44 00000 00
W 1f800000 2 0003ffff 00000 00
W 1f800004 2 00000155 00000 00
W 1f800008 2 12345678 00000 00
R 1f800000 2 0003ffff 00000 00
R 1f800008 2 12345678 00000 00
R 1f800080 2 0002a5a5 2a5a5 15
R 1f800084 2 00000015 2a5a5 15
R 00000020 2 77fe1234 00000 00
R 10000000 2 77fe1234 00000 00

// File: ahbMatrix.f
+incdir+hdl
hdl/ahbMatrixPkg.sv
hdl/ahbDecoder.sv
hdl/ahbResponseMux.sv
hdl/ahbRamSlave.sv
hdl/ahbGpioSlave.sv
hdl/ahbMatrix.sv
verif/ahbMatrix_sva.sv
verif/ahbMatrixTb.sv

// File: Makefile
VERILATOR = verilator
TOP       = ahbMatrixTb
FILELIST  = ahbMatrix.f
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
